/* hw/quick_spi_pkg.sv */
package quick_spi_pkg;

    // ########################################
    // Bus and memory geometry
    // ########################################
    localparam int AXI_DATA_WIDTH = 32;
    localparam int STRB_WIDTH = AXI_DATA_WIDTH / 8;
    localparam int AXI_ADDR_WIDTH = 8;
    localparam int MEMORY_SIZE = 64;
    localparam int BYTE_INDEX_WIDTH = $clog2(MEMORY_SIZE);
    localparam int WORD_INDEX_WIDTH = 4;
    localparam int FIELD_WIDTH = 16;
    localparam int WRITE_BUFFER_START = 12;
    localparam int READ_BUFFER_START = 38;

    // ########################################
    // Register map
    // ########################################
    localparam int CTRL_BYTE = 0;
    localparam int SLAVE_BYTE = 1;
    localparam int OUT_SIZE_BYTE = 2;     // Two bytes in little endian order.
    localparam int NUM_ELEMS_BYTE = 4;
    localparam int IN_SIZE_BYTE = 6;

    localparam int CPOL_BIT = 0;
    localparam int CPHA_BIT = 1;
    localparam int START_BIT = 2;
    localparam int BURST_BIT = 3;
    localparam int READ_BIT = 4;

    typedef struct packed {
        logic write_en;
        logic read_en;
        logic [WORD_INDEX_WIDTH-1:0] word_index;
        logic [AXI_DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } reg_access_t;

    typedef struct packed {
        logic cpol;
        logic cpha;
        logic start;
        logic burst;
        logic read;
        logic [7:0] slave;
        logic [FIELD_WIDTH-1:0] out_size;    // Bits per outgoing element.
        logic [FIELD_WIDTH-1:0] num_elems;
        logic [FIELD_WIDTH-1:0] in_size;
    } spi_config_t;

    typedef struct packed {
        logic valid;
        logic [BYTE_INDEX_WIDTH-1:0] byte_index;
        logic [2:0] bit_index;
    } capture_t;

    typedef enum logic [2:0] {
        SPI_IDLE,
        SPI_SELECT,
        SPI_SHIFT_OUT,
        SPI_SHIFT_IN,
        SPI_RELEASE
    } spi_state_e;

endpackage

/* hw/axi_burst_decode.sv */
module axi_burst_decode import quick_spi_pkg::*; (
    input  logic s_axi_aclk,
    input  logic s_axi_aresetn,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic [7:0] s_axi_awlen,
    input  logic s_axi_awvalid,
    output logic s_axi_awready,
    input  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata,
    input  logic [STRB_WIDTH-1:0] s_axi_wstrb,
    input  logic s_axi_wlast,
    input  logic s_axi_wvalid,
    output logic s_axi_wready,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic [7:0] s_axi_arlen,
    input  logic s_axi_arvalid,
    output logic s_axi_arready,
    input  logic bvalid,
    input  logic rvalid,
    input  logic s_axi_rready,
    output reg_access_t access,
    output logic write_last,
    output logic read_beat,
    output logic read_last
);
    localparam int ADDR_LSB = $clog2(STRB_WIDTH);

    logic write_open;
    logic read_open;
    logic read_final_sent;
    logic idle;
    logic w_beat;
    logic [WORD_INDEX_WIDTH-1:0] word_index;
    logic [7:0] burst_len;
    logic [8:0] beat_count;

    // A write stays blocking until its B handshake is done.
    assign idle = !write_open && !read_open && !bvalid;
    assign w_beat = s_axi_wready && s_axi_wvalid;
    assign write_last = w_beat && s_axi_wlast;
    assign read_beat = read_open && !rvalid && !read_final_sent;
    assign read_last = beat_count == {1'b0, burst_len};

    assign access.write_en = w_beat && (beat_count <= {1'b0, burst_len});  // Excess beats dropped.
    assign access.read_en = read_beat;
    assign access.word_index = word_index;
    assign access.data = s_axi_wdata;
    assign access.strb = s_axi_wstrb;

    // ########################################
    // Burst control
    // ########################################
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            write_open <= 1'b0;
            read_open <= 1'b0;
            read_final_sent <= 1'b0;
            s_axi_awready <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_wready <= 1'b0;
        end else begin
            s_axi_awready <= 1'b0;
            s_axi_arready <= 1'b0;
            if (idle && s_axi_awvalid) begin
                s_axi_awready <= 1'b1;     // Write wins a tie.
                write_open <= 1'b1;
            end else if (idle && s_axi_arvalid) begin
                s_axi_arready <= 1'b1;
                read_open <= 1'b1;
            end

            if (write_last) begin
                s_axi_wready <= 1'b0;
                write_open <= 1'b0;
            end else if (write_open && !s_axi_wready && s_axi_wvalid) begin
                s_axi_wready <= 1'b1;
            end

            if (read_beat && read_last) begin
                read_final_sent <= 1'b1;
            end
            if (read_final_sent && rvalid && s_axi_rready) begin
                read_open <= 1'b0;
                read_final_sent <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            word_index <= '0;
            burst_len <= '0;
            beat_count <= '0;
        end else if (idle && s_axi_awvalid) begin
            word_index <= s_axi_awaddr[ADDR_LSB +: WORD_INDEX_WIDTH];
            burst_len <= s_axi_awlen;
            beat_count <= '0;
        end else if (idle && s_axi_arvalid) begin
            word_index <= s_axi_araddr[ADDR_LSB +: WORD_INDEX_WIDTH];
            burst_len <= s_axi_arlen;
            beat_count <= '0;
        end else if (w_beat || read_beat) begin
            word_index <= word_index + 1'b1;    // INCR only.
            beat_count <= beat_count + 1'b1;
        end
    end

    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(write_open && read_open));

endmodule

/* hw/spi_register_file.sv */
module spi_register_file import quick_spi_pkg::*; (
    input  logic s_axi_aclk,
    input  logic s_axi_aresetn,
    input  reg_access_t access,
    input  capture_t capture,
    input  logic capture_bit,
    input  logic done,
    input  logic [BYTE_INDEX_WIDTH-1:0] write_byte_index,
    output logic [7:0] mosi_byte,
    output spi_config_t cfg,
    output logic [AXI_DATA_WIDTH-1:0] read_word
);
    logic [7:0] mem [MEMORY_SIZE];

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            for (int i = 0; i < WRITE_BUFFER_START; i++) begin
                mem[i] <= '0;          // Control bytes only.
            end
        end else begin
            if (done) begin
                mem[CTRL_BYTE][START_BIT] <= 1'b0;
            end
            if (capture.valid) begin
                mem[capture.byte_index][capture.bit_index] <= capture_bit;
            end
            if (access.write_en) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (access.strb[b]) begin
                        mem[access.word_index * STRB_WIDTH + b] <= access.data[b * 8 +: 8];
                    end
                end
            end
        end
    end

    // Held until the next read beat.
    always_ff @(posedge s_axi_aclk) begin
        if (access.read_en) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                read_word[b * 8 +: 8] <= mem[access.word_index * STRB_WIDTH + b];
            end
        end
    end

    assign mosi_byte = mem[write_byte_index];

    assign cfg.cpol = mem[CTRL_BYTE][CPOL_BIT];
    assign cfg.cpha = mem[CTRL_BYTE][CPHA_BIT];
    assign cfg.start = mem[CTRL_BYTE][START_BIT];
    assign cfg.burst = mem[CTRL_BYTE][BURST_BIT];
    assign cfg.read = mem[CTRL_BYTE][READ_BIT];
    assign cfg.slave = mem[SLAVE_BYTE];
    assign cfg.out_size = {mem[OUT_SIZE_BYTE + 1], mem[OUT_SIZE_BYTE]};
    assign cfg.num_elems = {mem[NUM_ELEMS_BYTE + 1], mem[NUM_ELEMS_BYTE]};
    assign cfg.in_size = {mem[IN_SIZE_BYTE + 1], mem[IN_SIZE_BYTE]};

    // The engine's bit address must never reach the control bytes or write buffer.
    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        capture.valid |-> capture.byte_index >= READ_BUFFER_START);

endmodule

/* hw/spi_shift_engine.sv */
module spi_shift_engine import quick_spi_pkg::*; #(
    parameter int NUMBER_OF_SLAVES = 2
) (
    input  logic s_axi_aclk,
    input  logic s_axi_aresetn,
    input  spi_config_t cfg,
    input  logic write_busy,
    input  logic [7:0] mosi_byte,
    output logic [BYTE_INDEX_WIDTH-1:0] write_byte_index,
    output logic mosi,
    input  logic miso,
    output logic sclk,
    output logic [NUMBER_OF_SLAVES-1:0] ss_n,
    output capture_t capture,
    output logic capture_bit,
    output logic done
);
    localparam int COUNT_WIDTH = 2 * FIELD_WIDTH;

    spi_state_e state;
    spi_config_t cfg_q;
    logic [COUNT_WIDTH-1:0] out_total;
    logic [COUNT_WIDTH-1:0] in_total;
    logic [COUNT_WIDTH-1:0] out_index;
    logic [COUNT_WIDTH-1:0] sample_count;
    logic sample_edge;

    assign out_total = cfg_q.burst ?
        COUNT_WIDTH'(cfg_q.out_size) * COUNT_WIDTH'(cfg_q.num_elems) :
        COUNT_WIDTH'(cfg_q.out_size);
    assign in_total = COUNT_WIDTH'(cfg_q.in_size);

    // Next sclk toggle is a sampling edge.
    assign sample_edge = (sclk == cfg_q.cpol) ^ cfg_q.cpha;

    assign write_byte_index = BYTE_INDEX_WIDTH'(WRITE_BUFFER_START + (out_index >> 3));

    assign capture.valid = (state == SPI_SHIFT_IN) && sample_edge;
    assign capture.byte_index = BYTE_INDEX_WIDTH'(READ_BUFFER_START + (sample_count >> 3));
    assign capture.bit_index = sample_count[2:0];
    assign capture_bit = miso;
    assign done = state == SPI_RELEASE;

    always_ff @(posedge s_axi_aclk) begin
        if (state == SPI_IDLE) begin
            cfg_q <= cfg;
        end
    end

    // ########################################
    // Frame FSM
    // ########################################
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= SPI_IDLE;
            sclk <= 1'b0;
            mosi <= 1'b0;
            ss_n <= '1;
            out_index <= '0;
            sample_count <= '0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    sclk <= cfg.cpol;
                    out_index <= '0;
                    sample_count <= '0;
                    if (cfg.start && !write_busy) begin
                        ss_n <= ~(NUMBER_OF_SLAVES'(1) << cfg.slave);
                        state <= SPI_SELECT;
                    end
                end
                SPI_SELECT: begin
                    if (!cfg_q.cpha) begin
                        mosi <= mosi_byte[out_index[2:0]];   // Bit 0 ahead of first edge.
                        out_index <= out_index + 1'b1;
                    end
                    state <= SPI_SHIFT_OUT;
                end
                SPI_SHIFT_OUT: begin
                    sclk <= ~sclk;
                    if (sample_edge) begin
                        sample_count <= sample_count + 1'b1;
                        if (sample_count == out_total - 1'b1) begin
                            sample_count <= '0;
                            state <= cfg_q.read ? SPI_SHIFT_IN : SPI_RELEASE;
                        end
                    end else begin
                        mosi <= mosi_byte[out_index[2:0]];
                        out_index <= out_index + 1'b1;
                    end
                end
                SPI_SHIFT_IN: begin
                    sclk <= ~sclk;
                    if (sample_edge) begin
                        sample_count <= sample_count + 1'b1;
                        if (sample_count == in_total - 1'b1) begin
                            state <= SPI_RELEASE;
                        end
                    end
                end
                SPI_RELEASE: begin
                    sclk <= cfg_q.cpol;
                    ss_n <= '1;
                    mosi <= 1'b0;
                    state <= SPI_IDLE;
                end
                default: begin
                    state <= SPI_IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (state == SPI_IDLE) ? (&ss_n) : $onehot(~ss_n));

endmodule

/* hw/axi_response.sv */
module axi_response import quick_spi_pkg::*; (
    input  logic s_axi_aclk,
    input  logic s_axi_aresetn,
    input  logic write_last,
    input  logic read_beat,
    input  logic read_last,
    input  logic [AXI_DATA_WIDTH-1:0] read_word,
    output logic [1:0] s_axi_bresp,
    output logic s_axi_bvalid,
    input  logic s_axi_bready,
    output logic [AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic s_axi_rlast,
    output logic s_axi_rvalid,
    input  logic s_axi_rready
);
    localparam logic [1:0] RESP_OKAY = 2'b00;

    assign s_axi_bresp = RESP_OKAY;
    assign s_axi_rresp = RESP_OKAY;
    assign s_axi_rdata = read_word;     // Registered in the memory and stable per beat.

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_bvalid <= 1'b0;
        end else if (write_last) begin
            s_axi_bvalid <= 1'b1;
        end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_rvalid <= 1'b0;
            s_axi_rlast <= 1'b0;
        end else if (read_beat) begin
            s_axi_rvalid <= 1'b1;
            s_axi_rlast <= read_last;
        end else if (s_axi_rvalid && s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            s_axi_rlast <= 1'b0;
        end
    end

endmodule

/* hw/quick_spi.sv */
module quick_spi import quick_spi_pkg::*; #(
    parameter int NUMBER_OF_SLAVES = 2
) (
    input  logic s_axi_aclk,
    input  logic s_axi_aresetn,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic [7:0] s_axi_awlen,
    input  logic s_axi_awvalid,
    output logic s_axi_awready,
    input  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata,
    input  logic [STRB_WIDTH-1:0] s_axi_wstrb,
    input  logic s_axi_wlast,
    input  logic s_axi_wvalid,
    output logic s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic s_axi_bvalid,
    input  logic s_axi_bready,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic [7:0] s_axi_arlen,
    input  logic s_axi_arvalid,
    output logic s_axi_arready,
    output logic [AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic s_axi_rlast,
    output logic s_axi_rvalid,
    input  logic s_axi_rready,
    output logic mosi,
    input  logic miso,
    output logic sclk,
    output logic [NUMBER_OF_SLAVES-1:0] ss_n
);
    reg_access_t access;
    spi_config_t cfg;
    capture_t capture;
    logic [AXI_DATA_WIDTH-1:0] read_word;
    logic [BYTE_INDEX_WIDTH-1:0] write_byte_index;
    logic [7:0] mosi_byte;
    logic capture_bit;
    logic done;
    logic write_last;
    logic read_beat;
    logic read_last;

    axi_burst_decode axi_burst_decode_i (
        .s_axi_aclk(s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .s_axi_awaddr(s_axi_awaddr),
        .s_axi_awlen(s_axi_awlen),
        .s_axi_awvalid(s_axi_awvalid),
        .s_axi_awready(s_axi_awready),
        .s_axi_wdata(s_axi_wdata),
        .s_axi_wstrb(s_axi_wstrb),
        .s_axi_wlast(s_axi_wlast),
        .s_axi_wvalid(s_axi_wvalid),
        .s_axi_wready(s_axi_wready),
        .s_axi_araddr(s_axi_araddr),
        .s_axi_arlen(s_axi_arlen),
        .s_axi_arvalid(s_axi_arvalid),
        .s_axi_arready(s_axi_arready),
        .bvalid(s_axi_bvalid),
        .rvalid(s_axi_rvalid),
        .s_axi_rready(s_axi_rready),
        .access(access),
        .write_last(write_last),
        .read_beat(read_beat),
        .read_last(read_last)
    );

    spi_register_file spi_register_file_i (
        .s_axi_aclk(s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .access(access),
        .capture(capture),
        .capture_bit(capture_bit),
        .done(done),
        .write_byte_index(write_byte_index),
        .mosi_byte(mosi_byte),
        .cfg(cfg),
        .read_word(read_word)
    );

    spi_shift_engine #(
        .NUMBER_OF_SLAVES(NUMBER_OF_SLAVES)
    ) spi_shift_engine_i (
        .s_axi_aclk(s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .cfg(cfg),
        .write_busy(access.write_en),   // A frame never starts under a write beat.
        .mosi_byte(mosi_byte),
        .write_byte_index(write_byte_index),
        .mosi(mosi),
        .miso(miso),
        .sclk(sclk),
        .ss_n(ss_n),
        .capture(capture),
        .capture_bit(capture_bit),
        .done(done)
    );

    axi_response axi_response_i (
        .s_axi_aclk(s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .write_last(write_last),
        .read_beat(read_beat),
        .read_last(read_last),
        .read_word(read_word),
        .s_axi_bresp(s_axi_bresp),
        .s_axi_bvalid(s_axi_bvalid),
        .s_axi_bready(s_axi_bready),
        .s_axi_rdata(s_axi_rdata),
        .s_axi_rresp(s_axi_rresp),
        .s_axi_rlast(s_axi_rlast),
        .s_axi_rvalid(s_axi_rvalid),
        .s_axi_rready(s_axi_rready)
    );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic s_axi_aclk,
    output logic s_axi_aresetn
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        s_axi_aclk = 1'b0;
        forever #HALF_PERIOD s_axi_aclk = ~s_axi_aclk;
    end

    initial begin
        s_axi_aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;     // Released on a falling edge.
    end

endmodule

/* test/quick_spi_tb.sv */
module quick_spi_tb import quick_spi_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SLAVES = 2;
    localparam int NUM_FRAMES = 4;
    localparam int MAX_BITS = 256;
    localparam int RESET_CYCLES = 8;
    localparam int BURST_TEST_CYCLES = 200;
    localparam int CYCLES_PER_BIT = 4;
    localparam int CYCLES_PER_FRAME = 200;
    localparam logic [15:0] LFSR_SEED = 16'd12;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;
    localparam int READ_WINDOW = 36;         // Word aligned window over bytes 36 to 63.
    localparam int READ_WINDOW_WORDS = 7;

    typedef struct packed {
        logic cpol;
        logic cpha;
        logic burst;
        logic read;
        logic [7:0] slave;
        logic [15:0] out_size;
        logic [15:0] num_elems;
        logic [15:0] in_size;
        logic [63:0] out_bytes;              // Byte 12 sits in bits 7:0.
    } frame_entry_t;

    logic s_axi_aclk;
    logic s_axi_aresetn;
    logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr;
    logic [7:0] s_axi_awlen;
    logic s_axi_awvalid;
    logic s_axi_awready;
    logic [AXI_DATA_WIDTH-1:0] s_axi_wdata;
    logic [STRB_WIDTH-1:0] s_axi_wstrb;
    logic s_axi_wlast;
    logic s_axi_wvalid;
    logic s_axi_wready;
    logic [1:0] s_axi_bresp;
    logic s_axi_bvalid;
    logic s_axi_bready;
    logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr;
    logic [7:0] s_axi_arlen;
    logic s_axi_arvalid;
    logic s_axi_arready;
    logic [AXI_DATA_WIDTH-1:0] s_axi_rdata;
    logic [1:0] s_axi_rresp;
    logic s_axi_rlast;
    logic s_axi_rvalid;
    logic s_axi_rready;
    logic mosi;
    logic miso;
    logic sclk;
    logic [SLAVES-1:0] ss_n;

    frame_entry_t frames [NUM_FRAMES];
    frame_entry_t cur;
    logic [31:0] wr_data [16];
    logic [3:0] wr_strb [16];
    logic [31:0] rd_data [16];
    logic [7:0] shadow [64];
    logic [15:0] lfsr_state;
    logic in_bits [MAX_BITS];
    logic mosi_bits [MAX_BITS];
    int mosi_count;
    int edge_count;
    int out_total;
    logic prev_sclk;
    logic prev_mosi;
    logic [SLAVES-1:0] prev_ss_n;
    logic [SLAVES-1:0] expected_ss_n;
    int cycle_count;
    int cycle_limit;

    tb_clock_gen clock_gen_i (
        .s_axi_aclk(s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn)
    );

    quick_spi #(
        .NUMBER_OF_SLAVES(SLAVES)
    ) quick_spi_i (.*);

    // ########################################
    // Checking helpers
    // ########################################
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else
            report_failure($sformatf("[FAIL] %s: got %h, expected %h", name, got, expected));
    endtask

    task automatic check_idle(input logic cpol);
        check_value("ss_n", 32'(ss_n), 32'({SLAVES{1'b1}}));
        check_value("sclk", 32'(sclk), 32'(cpol));
        check_value("mosi", 32'(mosi), 32'h0);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    function automatic int outgoing_bits(input frame_entry_t f);
        return f.burst ? int'(f.out_size) * int'(f.num_elems) : int'(f.out_size);
    endfunction

    function automatic int incoming_bits(input frame_entry_t f);
        return f.read ? int'(f.in_size) : 0;
    endfunction

    // ########################################
    // AXI driver
    // ########################################
    task automatic axi_write(input logic [7:0] addr, input int beats);
        int word;
        word = int'(addr) / 4;
        s_axi_awaddr = addr;
        s_axi_awlen = 8'(beats - 1);
        s_axi_awvalid = 1'b1;
        while (!s_axi_awready) @(negedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            s_axi_wdata = wr_data[i];
            s_axi_wstrb = wr_strb[i];
            s_axi_wlast = (i == beats - 1);
            s_axi_wvalid = 1'b1;
            while (!s_axi_wready) @(negedge s_axi_aclk);
            @(negedge s_axi_aclk);
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[i][b]) begin
                    shadow[(word + i) * 4 + b] = wr_data[i][b * 8 +: 8];
                end
            end
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast = 1'b0;
        check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'h1);   // One cycle after wlast.
        check_value("s_axi_bresp", 32'(s_axi_bresp), 32'h0);
        s_axi_bready = 1'b1;
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int beats);
        s_axi_araddr = addr;
        s_axi_arlen = 8'(beats - 1);
        s_axi_arvalid = 1'b1;
        while (!s_axi_arready) @(negedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            while (!s_axi_rvalid) @(negedge s_axi_aclk);
            rd_data[i] = s_axi_rdata;
            check_value("s_axi_rlast", 32'(s_axi_rlast), 32'(i == beats - 1));
            check_value("s_axi_rresp", 32'(s_axi_rresp), 32'h0);
            s_axi_rready = 1'b1;
            @(negedge s_axi_aclk);
            s_axi_rready = 1'b0;
        end
    endtask

    task automatic burst_test();
        logic [31:0] expected;
        for (int i = 0; i < 4; i++) begin
            wr_data[i] = 32'h0011_2233 + 32'(i) * 32'h0404_0404;
            wr_strb[i] = 4'hF;
        end
        axi_write(8'd40, 4);
        wr_data[0] = 32'hDEAD_BEEF;
        wr_data[1] = 32'hCAFE_F00D;
        wr_data[2] = 32'h5A5A_A5A5;
        wr_data[3] = 32'h1357_9BDF;
        wr_strb[0] = 4'b0101;
        wr_strb[1] = 4'b1010;
        wr_strb[2] = 4'b0110;
        wr_strb[3] = 4'b1001;
        axi_write(8'd40, 4);
        axi_read(8'd40, 4);
        for (int i = 0; i < 4; i++) begin
            expected = {shadow[43 + 4 * i], shadow[42 + 4 * i],
                        shadow[41 + 4 * i], shadow[40 + 4 * i]};
            check_value($sformatf("s_axi_rdata beat %0d", i), rd_data[i], expected);
        end
    endtask

    // ########################################
    // Frame sequence
    // ########################################
    task automatic run_frame(input frame_entry_t f);
        logic [7:0] ctrl;
        int in_total;
        int byte_addr;
        logic got;
        ctrl = '0;
        ctrl[CPOL_BIT] = f.cpol;
        ctrl[CPHA_BIT] = f.cpha;
        ctrl[BURST_BIT] = f.burst;
        ctrl[READ_BIT] = f.read;
        wr_data[0] = {f.out_size, f.slave, ctrl};
        wr_data[1] = {f.in_size, f.num_elems};
        wr_data[2] = 32'h0;                    // Unused bytes 8 to 11.
        wr_data[3] = f.out_bytes[31:0];
        wr_data[4] = f.out_bytes[63:32];
        for (int i = 0; i < 5; i++) begin
            wr_strb[i] = 4'hF;
        end
        axi_write(8'd0, 5);

        cur = f;
        out_total = outgoing_bits(f);
        in_total = incoming_bits(f);
        for (int k = 0; k < in_total; k++) begin
            in_bits[k] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        mosi_count = 0;
        edge_count = 0;
        check_idle(f.cpol);

        wr_data[0] = {24'h0, ctrl | (8'h1 << START_BIT)};
        wr_strb[0] = 4'b0001;
        axi_write(8'd0, 1);

        axi_read(8'd0, 1);
        while (rd_data[0][START_BIT]) axi_read(8'd0, 1);
        check_value("s_axi_rdata control word", rd_data[0], {f.out_size, f.slave, ctrl});
        check_idle(f.cpol);

        check_value("sclk sampling edges", 32'(edge_count), 32'(out_total + in_total));
        check_value("mosi bit count", 32'(mosi_count), 32'(out_total));
        for (int k = 0; k < out_total; k++) begin
            check_value($sformatf("mosi bit %0d", k), 32'(mosi_bits[k]), 32'(f.out_bytes[k]));
        end

        if (f.read) begin
            axi_read(8'(READ_WINDOW), READ_WINDOW_WORDS);
            for (int k = 0; k < in_total; k++) begin
                byte_addr = READ_BUFFER_START + k / 8;
                got = rd_data[byte_addr / 4 - READ_WINDOW / 4][(byte_addr % 4) * 8 + k % 8];
                check_value($sformatf("s_axi_rdata read buffer bit %0d", k), 32'(got),
                            32'(in_bits[k]));
            end
        end
    endtask

    // SPI slave model that looks at the bus once per clock between edges.
    always @(negedge s_axi_aclk) begin
        if (prev_ss_n != '1 && sclk != prev_sclk && ((prev_sclk == cur.cpol) ^ cur.cpha)) begin
            if (edge_count < out_total) begin
                assert (mosi === prev_mosi) else
                    report_failure("mosi changed on a sampling edge of sclk");
                mosi_bits[edge_count] = mosi;
                mosi_count++;
            end
            edge_count++;
        end
        if (s_axi_aresetn && ss_n != '1) begin
            expected_ss_n = ~(SLAVES'(1) << cur.slave);
            check_value("ss_n", 32'(ss_n), 32'(expected_ss_n));
        end
        if (edge_count >= out_total && edge_count - out_total < MAX_BITS) begin
            miso = in_bits[edge_count - out_total];
        end else begin
            miso = 1'b0;
        end
        prev_sclk = sclk;
        prev_ss_n = ss_n;
        prev_mosi = mosi;
    end

    always @(posedge s_axi_aclk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("Timeout after %0d cycles, the DUT stopped responding",
                                     cycle_count));
        end
    end

    initial begin
        frames[0] = '{cpol: 1'b0, cpha: 1'b0, burst: 1'b0, read: 1'b1, slave: 8'd0,
                      out_size: 16'd8, num_elems: 16'd1, in_size: 16'd8,
                      out_bytes: 64'h0123_4567_89AB_CDA5};
        frames[1] = '{cpol: 1'b1, cpha: 1'b1, burst: 1'b1, read: 1'b0, slave: 8'd1,
                      out_size: 16'd12, num_elems: 16'd3, in_size: 16'd0,
                      out_bytes: 64'hFEDC_BA98_7654_3210};
        frames[2] = '{cpol: 1'b0, cpha: 1'b1, burst: 1'b0, read: 1'b1, slave: 8'd1,
                      out_size: 16'd5, num_elems: 16'd4, in_size: 16'd13,
                      out_bytes: 64'h0F1E_2D3C_4B5A_6978};
        frames[3] = '{cpol: 1'b1, cpha: 1'b0, burst: 1'b1, read: 1'b1, slave: 8'd0,
                      out_size: 16'd8, num_elems: 16'd4, in_size: 16'd20,
                      out_bytes: 64'h5A5A_C3C3_0FF0_9669};
        cycle_limit = RESET_CYCLES + BURST_TEST_CYCLES;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            cycle_limit += CYCLES_PER_BIT * (outgoing_bits(frames[i]) + incoming_bits(frames[i]));
            cycle_limit += CYCLES_PER_FRAME;
        end
        cycle_count = 0;

        s_axi_awaddr = '0;
        s_axi_awlen = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '0;
        s_axi_wlast = 1'b0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arlen = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        miso = 1'b0;
        for (int k = 0; k < MAX_BITS; k++) begin
            in_bits[k] = 1'b0;
        end
        cur = '0;
        out_total = 0;
        edge_count = 0;
        mosi_count = 0;
        lfsr_state = LFSR_SEED;

        wait (s_axi_aresetn);
        @(negedge s_axi_aclk);
        check_idle(1'b0);
        check_value("s_axi_awready", 32'(s_axi_awready), 32'h0);
        check_value("s_axi_wready", 32'(s_axi_wready), 32'h0);
        check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'h0);
        check_value("s_axi_arready", 32'(s_axi_arready), 32'h0);
        check_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'h0);
        check_value("s_axi_rlast", 32'(s_axi_rlast), 32'h0);

        burst_test();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            run_frame(frames[i]);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* project.f */
hw/quick_spi_pkg.sv
hw/axi_burst_decode.sv
hw/spi_register_file.sv
hw/spi_shift_engine.sv
hw/axi_response.sv
hw/quick_spi.sv
test/tb_clock_gen.sv
test/quick_spi_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module quick_spi_tb

./obj_dir/Vquick_spi_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log
